/* all.f */
verilog/rtc_pkg.sv
verilog/rtc_bus_cycle.sv
verilog/rtc_write_seq.sv
verilog/rtc_reg_select.sv
verilog/rtc_write_top.sv
sim/rtc_write_assert.sv
sim/rtc_write_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rtc_write_tb -f all.f -o rtc_write_sim

# Assertion errors are counted by the testbench, so the run must not stop at the first one
output=$(./obj_dir/rtc_write_sim +verilator+error+limit+100000 || true)
echo "$output"

if echo "$output" | grep -q "^Simulation completed successfully$"; then
	exit 0
else
	exit 1
fi

/* sim/rtc_write_tb.sv */
module rtc_write_tb import rtc_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// Six tests of at most two writes of about 206 clocks each, with margin
	localparam int MAX_CYCLES = 3000;

	logic clk;
	logic reset;
	logic set_time;
	logic set_date;
	logic set_timer;
	logic stop_ring;
	logic init;
	logic arm_timer;
	logic a_d;
	logic cs;
	logic wr;
	rtc_sel_t addr_sel;
	rtc_sel_t data_sel;
	logic bus_drive;
	logic ready;
	logic busy;
	logic active;

	int cycles = 0;
	int tests_run = 0;
	int fails_before = 0;

	rtc_write_top rtc_write_top_i (.*);

	////////////////////////////////////////
	// Clock and timeout
	////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// Bit 0 is set_time, bit 5 is arm_timer
	task automatic drive_requests(logic [5:0] req);
		set_time = req[0];
		set_date = req[1];
		set_timer = req[2];
		stop_ring = req[3];
		init = req[4];
		arm_timer = req[5];
	endtask

	task automatic idle_clocks(int n);
		repeat (n) @(negedge clk);
	endtask

	// Holds the requests through a whole write and its done window
	task automatic full_write(logic [5:0] req);
		drive_requests(req);
		@(negedge clk);
		while (!ready) @(negedge clk);
		while (ready) @(negedge clk);
		drive_requests(6'b0);
		idle_clocks(3);
	endtask

	task automatic finish_test(string name);
		int now_fails;
		now_fails = rtc_write_top_i.rtc_write_check_i.fail_count;
		tests_run++;
		$display("Test %0d %s: %0d assertion failures", tests_run, name,
			now_fails - fails_before);
		fails_before = now_fails;
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	initial begin
		int wait_len;
		logic [5:0] mix;
		void'($urandom(93082));
		reset = 1'b1;
		drive_requests(6'b0);
		idle_clocks(8);
		reset = 1'b0;
		idle_clocks(5);
		finish_test("reset state");

		full_write(6'b000001);
		finish_test("set time held");

		// Mixes of at least two requests
		repeat (2) begin
			mix = 6'($urandom_range(0, 63));
			while ($countones(mix) < 2) mix = 6'($urandom_range(0, 63));
			full_write(mix);
		end
		finish_test("priority mixes");

		full_write(6'b100000);
		finish_test("arm timer alone");

		// Held past done so a second write starts after one idle clock
		drive_requests(6'b000010);
		@(negedge clk);
		while (!ready) @(negedge clk);
		while (ready) @(negedge clk);
		idle_clocks(3);
		drive_requests(6'b0);
		idle_clocks(3);
		finish_test("completion timing");

		drive_requests(6'b000100);
		@(negedge clk);
		while (!busy) @(negedge clk);
		wait_len = $urandom_range(1, 170);
		idle_clocks(wait_len);
		drive_requests(6'b0);
		idle_clocks(5);
		finish_test("abort");

		$display("Tests run %0d, assertion failures %0d", tests_run, fails_before);
		if (fails_before == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* sim/rtc_write_assert.sv */
module rtc_write_check import rtc_pkg::*; (
	input logic clk,
	input logic reset,
	input logic set_time,
	input logic set_date,
	input logic set_timer,
	input logic stop_ring,
	input logic init,
	input logic arm_timer,
	input logic a_d,
	input logic cs,
	input logic wr,
	input rtc_sel_t addr_sel,
	input rtc_sel_t data_sel,
	input logic bus_drive,
	input logic ready,
	input logic busy,
	input logic active
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;
	logic [8:0] busy_cnt;
	logic [5:0] ready_cnt;
	logic any_req;
	int phase;
	int exp_slot;
	int exp_reg;
	logic in_addr;
	logic in_data;
	logic in_wr;
	logic [2:0] exp_strobes;
	rtc_sel_t exp_addr;
	rtc_sel_t exp_data;

	// Register of each slot, rows in request priority order
	function automatic int reg_for(int req_idx, int slot);
		int r;
		r = 0;
		case (req_idx)
			0: r = (slot == 3) ? 9 : slot;
			1: r = (slot == 3) ? 9 : 3 + slot;
			2: r = (slot == 3) ? 10 : 6 + slot;
			3: r = 12;
			4: r = 13;
			default: r = (slot == 3) ? 11 : 12;
		endcase
		return r;
	endfunction

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy_cnt <= '0;
			ready_cnt <= '0;
		end else begin
			busy_cnt <= busy ? busy_cnt + 9'd1 : 9'd0;
			ready_cnt <= ready ? ready_cnt + 6'd1 : 6'd0;
		end
	end

	assign any_req = set_time || set_date || set_timer || stop_ring || init || arm_timer;

	always_comb begin
		phase = int'(busy_cnt) % SLOT_LEN;
		exp_slot = int'(busy_cnt) / SLOT_LEN;
		if (set_time) exp_reg = reg_for(0, exp_slot);
		else if (set_date) exp_reg = reg_for(1, exp_slot);
		else if (set_timer) exp_reg = reg_for(2, exp_slot);
		else if (stop_ring) exp_reg = reg_for(3, exp_slot);
		else if (init) exp_reg = reg_for(4, exp_slot);
		else exp_reg = reg_for(5, exp_slot);
		in_addr = busy && (phase >= 2) && (phase <= 20);
		in_data = busy && (phase >= 23) && (phase <= 41);
		in_wr = busy && (((phase >= 6) && (phase <= 15)) || ((phase >= 27) && (phase <= 36)));
		// a_d, cs and wr, all active low
		exp_strobes = {!in_addr, !(in_addr || in_data), !in_wr};
		exp_addr = (in_addr && any_req) ? (rtc_sel_t'(1) << exp_reg) : '0;
		exp_data = (in_data && any_req) ? (rtc_sel_t'(1) << exp_reg) : '0;
	end

	////////////////////////////////////////
	// Assertions
	////////////////////////////////////////

	reset_state: assert property (@(posedge clk) $fell(reset) |->
		a_d && cs && wr && addr_sel == '0 && data_sel == '0 && !ready && !busy && !active)
	else begin
		$error("Outputs not at their reset values after reset");
		fail_count++;
	end

	addr_value: assert property (@(posedge clk) disable iff (reset) addr_sel == exp_addr)
	else begin
		$error("MISMATCH addr_sel expected %h actual %h", $sampled(exp_addr),
			$sampled(addr_sel));
		fail_count++;
	end

	data_value: assert property (@(posedge clk) disable iff (reset) data_sel == exp_data)
	else begin
		$error("MISMATCH data_sel expected %h actual %h", $sampled(exp_data),
			$sampled(data_sel));
		fail_count++;
	end

	strobes: assert property (@(posedge clk) disable iff (reset)
		busy |-> {a_d, cs, wr} == exp_strobes)
	else begin
		$error("MISMATCH {a_d,cs,wr} expected %h actual %h", $sampled(exp_strobes),
			$sampled({a_d, cs, wr}));
		fail_count++;
	end

	drive_value: assert property (@(posedge clk) disable iff (reset)
		busy |-> bus_drive == (in_addr || in_data))
	else begin
		$error("MISMATCH bus_drive expected %h actual %h", $sampled(in_addr || in_data),
			$sampled(bus_drive));
		fail_count++;
	end

	ready_start: assert property (@(posedge clk) disable iff (reset)
		$rose(ready) |-> busy_cnt == 9'd172)
	else begin
		$error("MISMATCH busy_cnt expected %h actual %h", 9'd172, $sampled(busy_cnt));
		fail_count++;
	end

	ready_length: assert property (@(posedge clk) disable iff (reset)
		ready |-> ready_cnt < 6'd30)
	else begin
		$error("Done window is longer than 30 clocks");
		fail_count++;
	end

	ready_end: assert property (@(posedge clk) disable iff (reset)
		$fell(ready) && any_req |-> ready_cnt == 6'd30)
	else begin
		$error("MISMATCH ready_cnt expected %h actual %h", 6'd30, $sampled(ready_cnt));
		fail_count++;
	end

	active_flag: assert property (@(posedge clk) disable iff (reset)
		active == (busy || ready))
	else begin
		$error("MISMATCH active expected %h actual %h", $sampled(busy || ready),
			$sampled(active));
		fail_count++;
	end

	write_start: assert property (@(posedge clk) disable iff (reset)
		!active && any_req |=> busy)
	else begin
		$error("busy did not rise on the clock after a request");
		fail_count++;
	end

	write_abort: assert property (@(posedge clk) disable iff (reset)
		busy && !any_req |=> !busy && !ready)
	else begin
		$error("busy did not fall on the clock after the requests dropped");
		fail_count++;
	end

endmodule

bind rtc_write_top rtc_write_check rtc_write_check_i (.*);

/* verilog/rtc_write_top.sv */
module rtc_write_top import rtc_pkg::*; (
	input logic clk,
	input logic reset,
	input logic set_time,
	input logic set_date,
	input logic set_timer,
	input logic stop_ring,
	input logic init,
	input logic arm_timer,
	output logic a_d,
	output logic cs,
	output logic wr,
	output rtc_sel_t addr_sel,
	output rtc_sel_t data_sel,
	output logic bus_drive,
	output logic ready,
	output logic busy,
	output logic active
);

	logic cycle_run;
	logic cycle_end;
	logic send_add;
	logic send_data;
	rtc_cmd_e cmd;
	slot_t slot;

	////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////

	rtc_write_seq rtc_write_seq_i (
		.clk(clk),
		.reset(reset),
		.set_time(set_time),
		.set_date(set_date),
		.set_timer(set_timer),
		.stop_ring(stop_ring),
		.init(init),
		.arm_timer(arm_timer),
		.cycle_end(cycle_end),
		.cycle_run(cycle_run),
		.busy(busy),
		.active(active),
		.ready(ready),
		.cmd(cmd),
		.slot(slot)
	);

	////////////////////////////////////////
	// Bus cycle generator
	////////////////////////////////////////

	rtc_bus_cycle rtc_bus_cycle_i (
		.clk(clk),
		.reset(reset),
		.cycle_run(cycle_run),
		.a_d(a_d),
		.cs(cs),
		.wr(wr),
		.send_add(send_add),
		.send_data(send_data),
		.cycle_end(cycle_end)
	);

	// Register select per phase
	rtc_reg_select rtc_reg_select_i (
		.send_add(send_add),
		.send_data(send_data),
		.cmd(cmd),
		.slot(slot),
		.addr_sel(addr_sel),
		.data_sel(data_sel),
		.bus_drive(bus_drive)
	);

endmodule

/* verilog/rtc_reg_select.sv */
module rtc_reg_select import rtc_pkg::*; (
	input logic send_add,
	input logic send_data,
	input rtc_cmd_e cmd,
	input slot_t slot,
	output rtc_sel_t addr_sel,
	output rtc_sel_t data_sel,
	output logic bus_drive
);

	rtc_reg_e target;
	rtc_sel_t target_sel;

	////////////////////////////////////////
	// Target lookup
	////////////////////////////////////////

	assign target = slot_target(cmd, slot);

	// One-hot of the slot target, empty without a command
	always_comb begin
		target_sel = '0;
		if (cmd != CMD_NONE) begin
			target_sel[target] = 1'b1;
		end
	end

	////////////////////////////////////////
	// Phase gating
	////////////////////////////////////////

	// Address and data phases never overlap, so at most one vector is set
	always_comb begin
		if (send_add) begin
			addr_sel = target_sel;
		end else begin
			addr_sel = '0;
		end
	end

	always_comb begin
		if (send_data) begin
			data_sel = target_sel;
		end else begin
			data_sel = '0;
		end
	end

	// Enables the external bus buffer during either phase
	assign bus_drive = send_add || send_data;

endmodule

/* verilog/rtc_write_seq.sv */
module rtc_write_seq import rtc_pkg::*; (
	input logic clk,
	input logic reset,
	input logic set_time,
	input logic set_date,
	input logic set_timer,
	input logic stop_ring,
	input logic init,
	input logic arm_timer,
	input logic cycle_end,
	output logic cycle_run,
	output logic busy,
	output logic active,
	output logic ready,
	output rtc_cmd_e cmd,
	output slot_t slot
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITE,
		ST_DONE
	} state_e;

	state_e state;
	state_e state_next;
	logic any_req;
	logic last_slot;
	logic [DONE_W-1:0] done_cnt;

	////////////////////////////////////////
	// Request priority
	////////////////////////////////////////

	assign any_req = set_time || set_date || set_timer || stop_ring || init || arm_timer;

	// Fixed order, set time wins
	always_comb begin
		if (set_time) begin
			cmd = CMD_SET_TIME;
		end else if (set_date) begin
			cmd = CMD_SET_DATE;
		end else if (set_timer) begin
			cmd = CMD_SET_TIMER;
		end else if (stop_ring) begin
			cmd = CMD_STOP_RING;
		end else if (init) begin
			cmd = CMD_INIT;
		end else if (arm_timer) begin
			cmd = CMD_ARM_TIMER;
		end else begin
			cmd = CMD_NONE;
		end
	end

	////////////////////////////////////////
	// Idle / write / done FSM
	////////////////////////////////////////

	assign last_slot = cycle_end && (slot == slot_t'(NUM_SLOTS - 1));

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (any_req) begin
					state_next = ST_WRITE;
				end
			end
			ST_WRITE: begin
				// Dropping every request aborts the write
				if (!any_req) begin
					state_next = ST_IDLE;
				end else if (last_slot) begin
					state_next = ST_DONE;
				end
			end
			ST_DONE: begin
				if (!any_req || (done_cnt == DONE_W'(DONE_LEN - 1))) begin
					state_next = ST_IDLE;
				end
			end
			default: state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Slot advances on each cycle end and wraps after the last
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			slot <= '0;
		end else if (state != ST_WRITE) begin
			slot <= '0;
		end else if (cycle_end) begin
			slot <= slot + 1'b1;
		end
	end

	// Done window length
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			done_cnt <= '0;
		end else if (state != ST_DONE) begin
			done_cnt <= '0;
		end else begin
			done_cnt <= done_cnt + 1'b1;
		end
	end

	assign cycle_run = (state == ST_WRITE);
	assign busy = (state == ST_WRITE);
	assign ready = (state == ST_DONE);
	assign active = (state == ST_WRITE) || (state == ST_DONE);

endmodule

/* verilog/rtc_bus_cycle.sv */
module rtc_bus_cycle import rtc_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cycle_run,
	output logic a_d,
	output logic cs,
	output logic wr,
	output logic send_add,
	output logic send_data,
	output logic cycle_end
);

	logic [PHASE_W-1:0] phase;
	logic [PHASE_W-1:0] phase_next;
	logic in_addr;
	logic in_data;
	logic in_wr;

	function automatic logic in_window(logic [PHASE_W-1:0] p, int first, int last);
		return (int'(p) >= first) && (int'(p) <= last);
	endfunction

	////////////////////////////////////////
	// Phase counter
	////////////////////////////////////////

	// Counts 0 to SLOT_LEN-1 while running, parked at 0 otherwise
	always_comb begin
		if (!cycle_run) begin
			phase_next = '0;
		end else if (phase == PHASE_W'(SLOT_LEN - 1)) begin
			phase_next = '0;
		end else begin
			phase_next = phase + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= '0;
		end else begin
			phase <= phase_next;
		end
	end

	////////////////////////////////////////
	// Strobe decode
	////////////////////////////////////////

	// Decoded from the next phase so the registered strobes line up with phase
	assign in_addr = in_window(phase_next, ADDR_FIRST, ADDR_LAST);
	assign in_data = in_window(phase_next, DATA_FIRST, DATA_LAST);
	assign in_wr = in_window(phase_next, WR_ADDR_FIRST, WR_ADDR_LAST)
		|| in_window(phase_next, WR_DATA_FIRST, WR_DATA_LAST);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			a_d <= 1'b1;
			cs <= 1'b1;
			wr <= 1'b1;
			send_add <= 1'b0;
			send_data <= 1'b0;
			cycle_end <= 1'b0;
		end else begin
			// Address latch phase drives a_d low
			a_d <= !in_addr;
			cs <= !(in_addr || in_data);
			wr <= !in_wr;
			send_add <= in_addr;
			send_data <= in_data;
			// Last phase of the cycle
			cycle_end <= cycle_run && (phase_next == PHASE_W'(SLOT_LEN - 1));
		end
	end

endmodule

/* verilog/rtc_pkg.sv */
package rtc_pkg;

	////////////////////////////////////////
	// Bus write cycle timing
	////////////////////////////////////////

	// Clocks per multiplexed write cycle
	localparam int SLOT_LEN = 43;
	localparam int NUM_SLOTS = 4;
	localparam int DONE_LEN = 30;

	// Phase bounds, inclusive
	localparam int ADDR_FIRST = 2;
	localparam int ADDR_LAST = 20;
	localparam int DATA_FIRST = 23;
	localparam int DATA_LAST = 41;
	localparam int WR_ADDR_FIRST = 6;
	localparam int WR_ADDR_LAST = 15;
	localparam int WR_DATA_FIRST = 27;
	localparam int WR_DATA_LAST = 36;

	localparam int PHASE_W = $clog2(SLOT_LEN);
	localparam int DONE_W = $clog2(DONE_LEN);
	localparam int NUM_REGS = 14;

	////////////////////////////////////////
	// Registers and commands
	////////////////////////////////////////

	typedef enum logic [3:0] {
		REG_SECONDS,
		REG_MINUTES,
		REG_HOURS,
		REG_DAY,
		REG_MONTH,
		REG_YEAR,
		REG_TMR_SECONDS,
		REG_TMR_MINUTES,
		REG_TMR_HOURS,
		REG_CLK_CMD,
		REG_TMR_CMD,
		REG_STATUS0,
		REG_STATUS1,
		REG_STATUS2
	} rtc_reg_e;

	// One bit per chip register, indexed by rtc_reg_e
	typedef logic [NUM_REGS-1:0] rtc_sel_t;

	typedef enum logic [2:0] {
		CMD_SET_TIME,
		CMD_SET_DATE,
		CMD_SET_TIMER,
		CMD_STOP_RING,
		CMD_INIT,
		CMD_ARM_TIMER,
		CMD_NONE
	} rtc_cmd_e;

	typedef logic [1:0] slot_t;

	// Target register of each write slot
	function automatic rtc_reg_e slot_target(rtc_cmd_e cmd, slot_t slot);
		rtc_reg_e target;
		target = REG_STATUS0;
		case (cmd)
			CMD_SET_TIME: begin
				case (slot)
					2'd0: target = REG_SECONDS;
					2'd1: target = REG_MINUTES;
					2'd2: target = REG_HOURS;
					default: target = REG_CLK_CMD;
				endcase
			end
			CMD_SET_DATE: begin
				case (slot)
					2'd0: target = REG_DAY;
					2'd1: target = REG_MONTH;
					2'd2: target = REG_YEAR;
					default: target = REG_CLK_CMD;
				endcase
			end
			CMD_SET_TIMER: begin
				case (slot)
					2'd0: target = REG_TMR_SECONDS;
					2'd1: target = REG_TMR_MINUTES;
					2'd2: target = REG_TMR_HOURS;
					default: target = REG_TMR_CMD;
				endcase
			end
			CMD_STOP_RING: target = REG_STATUS1;
			CMD_INIT: target = REG_STATUS2;
			// Status 1 in the first three slots, status 0 only in the last
			CMD_ARM_TIMER: target = (slot == 2'd3) ? REG_STATUS0 : REG_STATUS1;
			// No command, the caller masks the result
			default: target = REG_STATUS0;
		endcase
		return target;
	endfunction

endpackage
